//--- scene_bank.f
hdl/isa_pkg.sv
hdl/scene_pkg.sv
hdl/scene_ram.sv
hdl/update_pipeline.sv
hdl/bank_arbiter.sv
hdl/scene_bank.sv
tests/scene_bank_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the scene bank testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f scene_bank.f --top-module scene_bank_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vscene_bank_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- tests/scene_bank_tb.sv
`timescale 1ns/1ns

module scene_bank_tb;
    import isa_pkg::*;
    import scene_pkg::*;

    localparam int NUM_LIGHTS       = DEFAULT_NUM_LIGHTS;
    localparam int NUM_SHAPES       = DEFAULT_NUM_SHAPES;
    localparam int LIGHT_ADDR_WIDTH = (NUM_LIGHTS > 1) ? $clog2(NUM_LIGHTS) : 1;
    localparam int SHAPE_ADDR_WIDTH = (NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1;
    localparam int CAMERA_PROPS     = 13;
    localparam int LIGHT_PROPS      = 9;
    localparam int SHAPE_PROPS      = 13;
    localparam int RENDER_READS     = (NUM_SHAPES > NUM_LIGHTS) ? NUM_SHAPES : NUM_LIGHTS;
    localparam int RANDOM_WRITES    = 48;
    localparam int RUN_COUNT        = 6;
    localparam int RUN_LENGTH       = 4;
    localparam int BAD_INDEX_WRITES = 3;
    localparam int LATE_WRITES      = 10;     // First one is offered during render
    localparam int PLANNED = RANDOM_WRITES + RUN_COUNT * RUN_LENGTH + BAD_INDEX_WRITES
                           + LATE_WRITES + 2;
    localparam int TIMEOUT_NS = (50 * PLANNED + 200) * 10;

    logic                        clk_100mhz = 1'b0;
    logic                        rst;
    logic                        inst_valid;
    logic                        inst_ready;
    op_t                         inst_op;
    prop_t                       inst_prop;
    logic [INDEX_WIDTH-1:0]      inst_index;
    logic [PROP_DATA_WIDTH-1:0]  inst_data;
    logic                        controller_busy;
    logic [LIGHT_ADDR_WIDTH-1:0] render_light_index;
    logic [SHAPE_ADDR_WIDTH-1:0] render_shape_index;
    logic                        render_enable;
    camera_t                     camera_out;
    light_t                      light_out;
    shape_t                      shape_out;

    logic [15:0] camera_model [CAMERA_PROPS];
    logic [15:0] light_model  [NUM_LIGHTS][LIGHT_PROPS];
    logic [15:0] shape_model  [NUM_SHAPES][SHAPE_PROPS];

    int   errors = 0;
    int   checks = 0;
    logic frame_accept;
    logic saw_busy;                           // Renderer went busy in this render phase

    scene_bank #(.NUM_LIGHTS(NUM_LIGHTS), .NUM_SHAPES(NUM_SHAPES)) i_dut (
        .clk_100mhz, .rst, .inst_valid, .inst_ready, .inst_op, .inst_prop,
        .inst_index, .inst_data, .controller_busy,
        .render_light_index, .render_shape_index,
        .render_enable, .camera_out, .light_out, .shape_out
    );

    always #5 clk_100mhz = ~clk_100mhz;

    assign frame_accept = inst_valid && inst_ready && inst_op == op_frame;

    always_ff @(posedge clk_100mhz) begin
        if (rst || !render_enable) begin
            saw_busy <= 1'b0;
        end else if (controller_busy) begin
            saw_busy <= 1'b1;
        end
    end

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    after_reset: assert property (@(posedge clk_100mhz) $fell(rst) |-> inst_ready && !render_enable)
        else report_failure("inst_ready low or render_enable high right after reset");
    frame_stops_input: assert property (@(posedge clk_100mhz) disable iff (rst)
        $past(frame_accept) |-> !inst_ready && !render_enable)
        else report_failure("inst_ready did not fall in the cycle after a frame");
    frame_in_flight: assert property (@(posedge clk_100mhz) disable iff (rst)
        $past(frame_accept, 2) |-> !inst_ready && !render_enable)
        else report_failure("render mode began too early after a frame");
    frame_to_render: assert property (@(posedge clk_100mhz) disable iff (rst)
        $past(frame_accept, 3) |-> render_enable)
        else report_failure("render_enable not high 3 cycles after a frame");
    render_start: assert property (@(posedge clk_100mhz) disable iff (rst)
        $rose(render_enable) |-> $past(frame_accept, 3))
        else report_failure("render_enable rose without a frame 3 cycles before");
    render_hold: assert property (@(posedge clk_100mhz) disable iff (rst)
        render_enable |-> !inst_ready)
        else report_failure("instruction input open during render");
    render_end: assert property (@(posedge clk_100mhz) disable iff (rst)
        $fell(render_enable) |-> inst_ready && $past(saw_busy && !controller_busy))
        else report_failure("render ended without a busy then idle controller");

    task automatic apply_to_model(input op_t op, input int index, input prop_t prop,
                                  input logic [15:0] data);
        case (op)
            op_camera_set: if (prop < CAMERA_PROPS) camera_model[prop] = data;
            op_light_set: begin
                if (index < NUM_LIGHTS && prop < LIGHT_PROPS) begin
                    light_model[index][prop] = (prop == lt_type) ? {14'd0, data[1:0]} : data;
                end
            end
            op_shape_set: begin
                if (index < NUM_SHAPES && prop < SHAPE_PROPS) begin
                    if (prop == sh_material) begin
                        shape_model[index][prop] = {14'd0, data[1:0]};
                    end else if (prop == sh_type) begin
                        shape_model[index][prop] = {12'd0, data[3:0]};
                    end else begin
                        shape_model[index][prop] = data;
                    end
                end
            end
            default: ;                        // Frame and nop leave the records alone
        endcase
    endtask

    function automatic camera_t expected_camera();
        camera_t rec;
        for (int f = 0; f < CAMERA_PROPS; f++) begin
            rec[16*(CAMERA_PROPS-1-f) +: 16] = camera_model[f];  // Code 0 in the top bits
        end
        return rec;
    endfunction

    function automatic light_t expected_light(input int idx);
        light_t rec;
        rec.light_type = light_model[idx][0][1:0];
        for (int f = 1; f < LIGHT_PROPS; f++) begin
            rec[16*(LIGHT_PROPS-1-f) +: 16] = light_model[idx][f];
        end
        return rec;
    endfunction

    function automatic shape_t expected_shape(input int idx);
        shape_t rec;
        for (int f = 0; f < 11; f++) begin
            rec[6 + 16*(10-f) +: 16] = shape_model[idx][f];  // Above material and type
        end
        rec.material   = shape_model[idx][11][1:0];
        rec.shape_type = shape_model[idx][12][3:0];
        return rec;
    endfunction

    task automatic send_instruction(input op_t op, input int index, input prop_t prop,
                                    input logic [15:0] data, input int gap);
        inst_valid = 1'b1;
        inst_op    = op;
        inst_index = index[INDEX_WIDTH-1:0];
        inst_prop  = prop;
        inst_data  = data;
        @(negedge clk_100mhz);
        while (!inst_ready) @(negedge clk_100mhz);  // Ready only moves on a rising edge
        @(posedge clk_100mhz);
        #1;
        apply_to_model(op, index, prop, data);
        if (gap > 0) begin
            inst_valid = 1'b0;
            repeat (gap) @(posedge clk_100mhz);
            #1;
        end
    endtask

    task automatic random_instruction(input int gap);
        op_t op;
        int  index;
        case ($urandom_range(0, 2))
            0: begin
                op    = op_camera_set;
                index = 0;
            end
            1: begin
                op    = op_light_set;
                index = $urandom_range(0, NUM_LIGHTS - 1);
            end
            default: begin
                op    = op_shape_set;
                index = $urandom_range(0, NUM_SHAPES - 1);
            end
        endcase
        // Codes 13 to 15 are never valid
        send_instruction(op, index, prop_t'($urandom_range(0, 15)),
                         16'($urandom_range(0, 65535)), gap);
    endtask

    task automatic same_record_run();
        op_t op;
        int  index;
        int  count;
        case ($urandom_range(0, 2))
            0: begin
                op    = op_camera_set;
                index = 0;
                count = CAMERA_PROPS;
            end
            1: begin
                op    = op_light_set;
                index = $urandom_range(0, NUM_LIGHTS - 1);
                count = LIGHT_PROPS;
            end
            default: begin
                op    = op_shape_set;
                index = $urandom_range(0, NUM_SHAPES - 1);
                count = SHAPE_PROPS;
            end
        endcase
        for (int k = 0; k < RUN_LENGTH; k++) begin
            send_instruction(op, index, prop_t'($urandom_range(0, count - 1)),
                             16'($urandom_range(0, 65535)), $urandom_range(0, 1));
        end
    endtask

    task automatic compare_outputs(input int light_idx, input int shape_idx);
        camera_t exp_camera;
        light_t  exp_light;
        shape_t  exp_shape;
        exp_camera = expected_camera();
        exp_light  = expected_light(light_idx);
        exp_shape  = expected_shape(shape_idx);
        checks += 3;
        assert (camera_out === exp_camera) else begin
            errors++;
            $display("Mismatch at %0t ns: camera_out expected %h actual %h",
                     $time, exp_camera, camera_out);
        end
        assert (light_out === exp_light) else begin
            errors++;
            $display("Mismatch at %0t ns: light_out[%0d] expected %h actual %h",
                     $time, light_idx, exp_light, light_out);
        end
        assert (shape_out === exp_shape) else begin
            errors++;
            $display("Mismatch at %0t ns: shape_out[%0d] expected %h actual %h",
                     $time, shape_idx, exp_shape, shape_out);
        end
    endtask

    task automatic render_and_check();
        int light_idx;
        int shape_idx;
        while (!render_enable) @(negedge clk_100mhz);
        @(posedge clk_100mhz);
        #1;
        for (int i = 0; i < RENDER_READS; i++) begin
            light_idx          = i % NUM_LIGHTS;
            shape_idx          = i % NUM_SHAPES;
            render_light_index = light_idx[LIGHT_ADDR_WIDTH-1:0];
            render_shape_index = shape_idx[SHAPE_ADDR_WIDTH-1:0];
            @(posedge clk_100mhz);            // Record is out one cycle after its index
            #1;
            compare_outputs(light_idx, shape_idx);
        end
        controller_busy = 1'b1;
        repeat (3) @(posedge clk_100mhz);
        #1;
        controller_busy = 1'b0;
        while (render_enable) @(negedge clk_100mhz);
        @(posedge clk_100mhz);
        #1;
    endtask

    initial begin
        void'($urandom(20386));
        rst                = 1'b1;
        inst_valid         = 1'b0;
        inst_op            = op_nop;
        inst_prop          = '0;
        inst_index         = '0;
        inst_data          = '0;
        controller_busy    = 1'b0;
        render_light_index = '0;
        render_shape_index = '0;
        foreach (camera_model[f]) camera_model[f] = '0;
        foreach (light_model[i, f]) light_model[i][f] = '0;
        foreach (shape_model[i, f]) shape_model[i][f] = '0;
        repeat (3) @(posedge clk_100mhz);
        #1;
        rst = 1'b0;

        for (int n = 0; n < RANDOM_WRITES; n++) begin
            random_instruction($urandom_range(0, 1));
        end
        for (int r = 0; r < RUN_COUNT; r++) begin
            same_record_run();
        end
        send_instruction(op_light_set, NUM_LIGHTS, lt_color, 16'hdead, 0);
        send_instruction(op_light_set, 255, lt_x_loc, 16'hbeef, 0);
        send_instruction(op_shape_set, NUM_SHAPES + 3, sh_color, 16'hface, 1);

        send_instruction(op_frame, 0, 4'd0, 16'd0, 0);
        fork
            send_instruction(op_light_set, 1, lt_color, 16'h5a5a, 1);  // Waits out the render
            render_and_check();
        join
        for (int n = 1; n < LATE_WRITES; n++) begin
            random_instruction($urandom_range(0, 1));
        end
        send_instruction(op_frame, 0, 4'd0, 16'd0, 1);
        render_and_check();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the bank stopped responding", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

endmodule

//--- hdl/scene_bank.sv
`timescale 1ns/1ns

module scene_bank #(
    parameter int NUM_LIGHTS = scene_pkg::DEFAULT_NUM_LIGHTS,
    parameter int NUM_SHAPES = scene_pkg::DEFAULT_NUM_SHAPES,
    localparam int LIGHT_ADDR_WIDTH = (NUM_LIGHTS > 1) ? $clog2(NUM_LIGHTS) : 1,
    localparam int SHAPE_ADDR_WIDTH = (NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1
) (
    input  logic                                clk_100mhz,
    input  logic                                rst,
    input  logic                                inst_valid,
    output logic                                inst_ready,
    input  isa_pkg::op_t                        inst_op,
    input  isa_pkg::prop_t                      inst_prop,
    input  logic [isa_pkg::INDEX_WIDTH-1:0]     inst_index,
    input  logic [isa_pkg::PROP_DATA_WIDTH-1:0] inst_data,
    input  logic                                controller_busy,
    input  logic [LIGHT_ADDR_WIDTH-1:0]         render_light_index,
    input  logic [SHAPE_ADDR_WIDTH-1:0]         render_shape_index,
    output logic                                render_enable,
    output scene_pkg::camera_t                  camera_out,
    output scene_pkg::light_t                   light_out,
    output scene_pkg::shape_t                   shape_out
);
    import scene_pkg::*;

    logic                        write_mode, frame_done;
    logic                        pipe_camera_we, pipe_light_we, pipe_shape_we;
    logic [LIGHT_ADDR_WIDTH-1:0] pipe_light_addr, light_addr;
    logic [SHAPE_ADDR_WIDTH-1:0] pipe_shape_addr, shape_addr;
    logic                        camera_we, light_we, shape_we;
    camera_t                     pipe_camera_wdata, camera_wdata, camera_rdata;
    light_t                      pipe_light_wdata, light_wdata, light_rdata;
    shape_t                      pipe_shape_wdata, shape_wdata, shape_rdata;

    update_pipeline #(.NUM_LIGHTS(NUM_LIGHTS), .NUM_SHAPES(NUM_SHAPES)) pipeline (
        .clk_100mhz, .rst, .inst_valid, .inst_ready, .inst_op, .inst_prop,
        .inst_index, .inst_data, .write_mode, .frame_done,
        .camera_rdata, .light_rdata, .shape_rdata,
        .camera_we(pipe_camera_we), .camera_wdata(pipe_camera_wdata),
        .light_addr(pipe_light_addr), .light_we(pipe_light_we), .light_wdata(pipe_light_wdata),
        .shape_addr(pipe_shape_addr), .shape_we(pipe_shape_we), .shape_wdata(pipe_shape_wdata)
    );

    bank_arbiter #(.NUM_LIGHTS(NUM_LIGHTS), .NUM_SHAPES(NUM_SHAPES)) arbiter (
        .clk_100mhz, .rst, .frame_done, .controller_busy,
        .pipe_camera_we, .pipe_camera_wdata,
        .pipe_light_addr, .pipe_light_we, .pipe_light_wdata,
        .pipe_shape_addr, .pipe_shape_we, .pipe_shape_wdata,
        .render_light_index, .render_shape_index,
        .camera_rdata, .light_rdata, .shape_rdata,
        .write_mode, .render_enable,
        .camera_we, .camera_wdata, .light_addr, .light_we, .light_wdata,
        .shape_addr, .shape_we, .shape_wdata,
        .camera_out, .light_out, .shape_out
    );

    scene_ram #(.DEPTH(1), .record_t(camera_t)) camera_ram (
        .clk_100mhz, .addr(1'b0), .we(camera_we), .wdata(camera_wdata), .rdata(camera_rdata)
    );

    scene_ram #(.DEPTH(NUM_LIGHTS), .record_t(light_t)) light_ram (
        .clk_100mhz, .addr(light_addr), .we(light_we), .wdata(light_wdata), .rdata(light_rdata)
    );

    scene_ram #(.DEPTH(NUM_SHAPES), .record_t(shape_t)) shape_ram (
        .clk_100mhz, .addr(shape_addr), .we(shape_we), .wdata(shape_wdata), .rdata(shape_rdata)
    );

endmodule

//--- hdl/bank_arbiter.sv
`timescale 1ns/1ns

module bank_arbiter #(
    parameter int NUM_LIGHTS = scene_pkg::DEFAULT_NUM_LIGHTS,
    parameter int NUM_SHAPES = scene_pkg::DEFAULT_NUM_SHAPES,
    localparam int LIGHT_ADDR_WIDTH = (NUM_LIGHTS > 1) ? $clog2(NUM_LIGHTS) : 1,
    localparam int SHAPE_ADDR_WIDTH = (NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1
) (
    input  logic                        clk_100mhz,
    input  logic                        rst,
    input  logic                        frame_done,
    input  logic                        controller_busy,
    input  logic                        pipe_camera_we,
    input  scene_pkg::camera_t          pipe_camera_wdata,
    input  logic [LIGHT_ADDR_WIDTH-1:0] pipe_light_addr,
    input  logic                        pipe_light_we,
    input  scene_pkg::light_t           pipe_light_wdata,
    input  logic [SHAPE_ADDR_WIDTH-1:0] pipe_shape_addr,
    input  logic                        pipe_shape_we,
    input  scene_pkg::shape_t           pipe_shape_wdata,
    input  logic [LIGHT_ADDR_WIDTH-1:0] render_light_index,
    input  logic [SHAPE_ADDR_WIDTH-1:0] render_shape_index,
    input  scene_pkg::camera_t          camera_rdata,
    input  scene_pkg::light_t           light_rdata,
    input  scene_pkg::shape_t           shape_rdata,
    output logic                        write_mode,
    output logic                        render_enable,
    output logic                        camera_we,
    output scene_pkg::camera_t          camera_wdata,
    output logic [LIGHT_ADDR_WIDTH-1:0] light_addr,
    output logic                        light_we,
    output scene_pkg::light_t           light_wdata,
    output logic [SHAPE_ADDR_WIDTH-1:0] shape_addr,
    output logic                        shape_we,
    output scene_pkg::shape_t           shape_wdata,
    output scene_pkg::camera_t          camera_out,
    output scene_pkg::light_t           light_out,
    output scene_pkg::shape_t           shape_out
);

    typedef enum logic [1:0] {
        st_writing,
        st_render_wait,                    // Frame closed, renderer not started yet
        st_render_busy
    } state_t;

    state_t state;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            state <= st_writing;
        end else begin
            case (state)
                st_writing:     if (frame_done) state <= st_render_wait;
                st_render_wait: if (controller_busy) state <= st_render_busy;
                st_render_busy: if (!controller_busy) state <= st_writing;
                default:        state <= st_writing;
            endcase
        end
    end

    assign write_mode    = (state == st_writing);
    assign render_enable = !write_mode;

    // Pipeline owns the ports while writing, render indices otherwise
    assign light_addr   = write_mode ? pipe_light_addr : render_light_index;
    assign shape_addr   = write_mode ? pipe_shape_addr : render_shape_index;
    assign camera_we    = write_mode && pipe_camera_we;
    assign light_we     = write_mode && pipe_light_we;
    assign shape_we     = write_mode && pipe_shape_we;
    assign camera_wdata = pipe_camera_wdata;
    assign light_wdata  = pipe_light_wdata;
    assign shape_wdata  = pipe_shape_wdata;

    assign camera_out = render_enable ? camera_rdata : '0;  // Hide records mid-update
    assign light_out  = render_enable ? light_rdata  : '0;
    assign shape_out  = render_enable ? shape_rdata  : '0;

    // Pipeline stops accepting once a frame is in flight
    assert property (@(posedge clk_100mhz) disable iff (rst) frame_done |-> write_mode)
        else $error("bank_arbiter frame_done outside writing mode");

endmodule

//--- hdl/update_pipeline.sv
`timescale 1ns/1ns

module update_pipeline #(
    parameter int NUM_LIGHTS = scene_pkg::DEFAULT_NUM_LIGHTS,
    parameter int NUM_SHAPES = scene_pkg::DEFAULT_NUM_SHAPES,
    localparam int LIGHT_ADDR_WIDTH = (NUM_LIGHTS > 1) ? $clog2(NUM_LIGHTS) : 1,
    localparam int SHAPE_ADDR_WIDTH = (NUM_SHAPES > 1) ? $clog2(NUM_SHAPES) : 1
) (
    input  logic                                clk_100mhz,
    input  logic                                rst,
    input  logic                                inst_valid,
    output logic                                inst_ready,
    input  isa_pkg::op_t                        inst_op,
    input  isa_pkg::prop_t                      inst_prop,
    input  logic [isa_pkg::INDEX_WIDTH-1:0]     inst_index,
    input  logic [isa_pkg::PROP_DATA_WIDTH-1:0] inst_data,
    input  logic                                write_mode,
    output logic                                frame_done,
    input  scene_pkg::camera_t                  camera_rdata,
    input  scene_pkg::light_t                   light_rdata,
    input  scene_pkg::shape_t                   shape_rdata,
    output logic                                camera_we,
    output scene_pkg::camera_t                  camera_wdata,
    output logic [LIGHT_ADDR_WIDTH-1:0]         light_addr,
    output logic                                light_we,
    output scene_pkg::light_t                   light_wdata,
    output logic [SHAPE_ADDR_WIDTH-1:0]         shape_addr,
    output logic                                shape_we,
    output scene_pkg::shape_t                   shape_wdata
);
    import isa_pkg::*;
    import scene_pkg::*;

    logic accept;
    logic in_range;
    logic port_conflict;
    logic frame_pending;                   // op_frame accepted, not yet retired

    logic                       s2_valid;
    op_t                        s2_op;
    prop_t                      s2_prop;
    logic [INDEX_WIDTH-1:0]     s2_index;
    logic [PROP_DATA_WIDTH-1:0] s2_data;
    logic                       s2_in_range;

    logic                   s3_valid;
    op_t                    s3_op;
    logic [INDEX_WIDTH-1:0] s3_index;
    logic                   s3_in_range;
    logic                   s3_write;
    camera_t                s3_camera;
    light_t                 s3_light;
    shape_t                 s3_shape;

    logic                   byp_valid;     // Record written last cycle
    op_t                    byp_op;
    logic [INDEX_WIDTH-1:0] byp_index;
    camera_t                byp_camera;
    light_t                 byp_light;
    shape_t                 byp_shape;

    logic    fwd_s3;
    logic    fwd_byp;
    camera_t base_camera;
    light_t  base_light;
    shape_t  base_shape;
    camera_t merged_camera;
    light_t  merged_light;
    shape_t  merged_shape;

    always_comb begin
        case (inst_op)
            op_light_set: in_range = inst_index < NUM_LIGHTS;
            op_shape_set: in_range = inst_index < NUM_SHAPES;
            default:      in_range = 1'b1;  // Camera is a single record, index unused
        endcase
    end

    // One port per memory, so a new read must not hit a different record being written
    assign port_conflict = (light_we && inst_op == op_light_set && inst_index != s3_index)
                        || (shape_we && inst_op == op_shape_set && inst_index != s3_index);
    assign inst_ready = write_mode && !frame_pending && !port_conflict;
    assign accept     = inst_valid && inst_ready;

    always_ff @(posedge clk_100mhz) begin
        if (rst) begin
            s2_valid      <= 1'b0;
            s3_valid      <= 1'b0;
            byp_valid     <= 1'b0;
            frame_pending <= 1'b0;
        end else begin
            s2_valid  <= accept;
            s3_valid  <= s2_valid;
            byp_valid <= s3_write;
            if (accept && inst_op == op_frame) begin
                frame_pending <= 1'b1;
            end else if (frame_done) begin
                frame_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_100mhz) begin
        s2_op       <= inst_op;
        s2_prop     <= inst_prop;
        s2_index    <= inst_index;
        s2_data     <= inst_data;
        s2_in_range <= in_range;
        s3_op       <= s2_op;
        s3_index    <= s2_index;
        s3_in_range <= s2_in_range;
        s3_camera   <= merged_camera;
        s3_light    <= merged_light;
        s3_shape    <= merged_shape;
        byp_op      <= s3_op;
        byp_index   <= s3_index;
        byp_camera  <= s3_camera;
        byp_light   <= s3_light;
        byp_shape   <= s3_shape;
    end

    // Newest copy wins: stage 3 write, then last cycle's write, then memory
    assign fwd_s3  = s3_write && s3_op == s2_op
                  && (s2_op == op_camera_set || s3_index == s2_index);
    assign fwd_byp = byp_valid && byp_op == s2_op
                  && (s2_op == op_camera_set || byp_index == s2_index);
    assign base_camera = fwd_s3 ? s3_camera : (fwd_byp ? byp_camera : camera_rdata);
    assign base_light  = fwd_s3 ? s3_light  : (fwd_byp ? byp_light  : light_rdata);
    assign base_shape  = fwd_s3 ? s3_shape  : (fwd_byp ? byp_shape  : shape_rdata);

    always_comb begin
        merged_camera = base_camera;
        merged_light  = base_light;
        merged_shape  = base_shape;
        case (s2_prop)
            cam_x_loc:     merged_camera.x_loc     = s2_data;
            cam_y_loc:     merged_camera.y_loc     = s2_data;
            cam_z_loc:     merged_camera.z_loc     = s2_data;
            cam_x_fwd:     merged_camera.x_fwd     = s2_data;
            cam_y_fwd:     merged_camera.y_fwd     = s2_data;
            cam_z_fwd:     merged_camera.z_fwd     = s2_data;
            cam_x_up:      merged_camera.x_up      = s2_data;
            cam_y_up:      merged_camera.y_up      = s2_data;
            cam_z_up:      merged_camera.z_up      = s2_data;
            cam_near_clip: merged_camera.near_clip = s2_data;
            cam_far_clip:  merged_camera.far_clip  = s2_data;
            cam_h_fov:     merged_camera.h_fov     = s2_data;
            cam_v_fov:     merged_camera.v_fov     = s2_data;
            default:       ;                   // Unknown code leaves the record alone
        endcase
        case (s2_prop)
            lt_type:       merged_light.light_type = s2_data[1:0];
            lt_x_loc:      merged_light.x_loc      = s2_data;
            lt_y_loc:      merged_light.y_loc      = s2_data;
            lt_z_loc:      merged_light.z_loc      = s2_data;
            lt_x_fwd:      merged_light.x_fwd      = s2_data;
            lt_y_fwd:      merged_light.y_fwd      = s2_data;
            lt_z_fwd:      merged_light.z_fwd      = s2_data;
            lt_color:      merged_light.color      = s2_data;
            lt_intensity:  merged_light.intensity  = s2_data;
            default:       ;
        endcase
        case (s2_prop)
            sh_x_loc:      merged_shape.x_loc      = s2_data;
            sh_y_loc:      merged_shape.y_loc      = s2_data;
            sh_z_loc:      merged_shape.z_loc      = s2_data;
            sh_r_rot:      merged_shape.r_rot      = s2_data;
            sh_i_rot:      merged_shape.i_rot      = s2_data;
            sh_j_rot:      merged_shape.j_rot      = s2_data;
            sh_k_rot:      merged_shape.k_rot      = s2_data;
            sh_x_scale:    merged_shape.x_scale    = s2_data;
            sh_y_scale:    merged_shape.y_scale    = s2_data;
            sh_z_scale:    merged_shape.z_scale    = s2_data;
            sh_color:      merged_shape.color      = s2_data;
            sh_material:   merged_shape.material   = s2_data[1:0];
            sh_type:       merged_shape.shape_type = s2_data[3:0];
            default:       ;
        endcase
    end

    assign camera_we    = s3_valid && s3_in_range && s3_op == op_camera_set;
    assign light_we     = s3_valid && s3_in_range && s3_op == op_light_set;
    assign shape_we     = s3_valid && s3_in_range && s3_op == op_shape_set;
    assign s3_write     = camera_we || light_we || shape_we;
    assign camera_wdata = s3_camera;
    assign light_wdata  = s3_light;
    assign shape_wdata  = s3_shape;
    assign light_addr   = light_we ? s3_index[LIGHT_ADDR_WIDTH-1:0]
                                   : inst_index[LIGHT_ADDR_WIDTH-1:0];
    assign shape_addr   = shape_we ? s3_index[SHAPE_ADDR_WIDTH-1:0]
                                   : inst_index[SHAPE_ADDR_WIDTH-1:0];
    assign frame_done   = s3_valid && s3_op == op_frame;

    // All writes ahead of a frame retire before the bank leaves writing mode
    assert property (@(posedge clk_100mhz) disable iff (rst) !write_mode |-> !s3_write)
        else $error("update_pipeline write outside writing mode");

endmodule

//--- hdl/scene_ram.sv
`timescale 1ns/1ns

module scene_ram #(
    parameter int DEPTH = 1,
    parameter type record_t = logic [15:0],
    localparam int ADDR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                  clk_100mhz,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  we,
    input  record_t               wdata,
    output record_t               rdata
);

    record_t mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;                   // Empty scene at power up
        end
    end

    always_ff @(posedge clk_100mhz) begin
        rdata <= mem[addr];                // Read-first, old record on a write
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Writers range-check their index upstream
    assert property (@(posedge clk_100mhz) we |-> addr < DEPTH)
        else $error("scene_ram write beyond depth, addr %0d", addr);

endmodule

//--- hdl/scene_pkg.sv
package scene_pkg;

    localparam int DEFAULT_NUM_LIGHTS = 4;
    localparam int DEFAULT_NUM_SHAPES = 16;

    typedef logic [15:0] field_t;

    typedef struct packed {
        field_t x_loc;
        field_t y_loc;
        field_t z_loc;
        field_t x_fwd;
        field_t y_fwd;
        field_t z_fwd;
        field_t x_up;
        field_t y_up;
        field_t z_up;
        field_t near_clip;
        field_t far_clip;
        field_t h_fov;
        field_t v_fov;
    } camera_t;

    typedef struct packed {
        logic [1:0] light_type;
        field_t     x_loc;
        field_t     y_loc;
        field_t     z_loc;
        field_t     x_fwd;
        field_t     y_fwd;
        field_t     z_fwd;
        field_t     color;
        field_t     intensity;
    } light_t;

    typedef struct packed {
        field_t     x_loc;
        field_t     y_loc;
        field_t     z_loc;
        field_t     r_rot;
        field_t     i_rot;
        field_t     j_rot;
        field_t     k_rot;
        field_t     x_scale;
        field_t     y_scale;
        field_t     z_scale;
        field_t     color;
        logic [1:0] material;
        logic [3:0] shape_type;
    } shape_t;

endpackage

//--- hdl/isa_pkg.sv
package isa_pkg;

    localparam int PROP_DATA_WIDTH = 16;  // Property data field
    localparam int INDEX_WIDTH     = 8;   // Record index field

    typedef enum logic [2:0] {
        op_nop,
        op_camera_set,
        op_light_set,
        op_shape_set,
        op_frame                          // Ends the writing phase
    } op_t;

    typedef logic [3:0] prop_t;           // Meaning depends on op_t

    localparam prop_t cam_x_loc     = 4'd0;
    localparam prop_t cam_y_loc     = 4'd1;
    localparam prop_t cam_z_loc     = 4'd2;
    localparam prop_t cam_x_fwd     = 4'd3;
    localparam prop_t cam_y_fwd     = 4'd4;
    localparam prop_t cam_z_fwd     = 4'd5;
    localparam prop_t cam_x_up      = 4'd6;
    localparam prop_t cam_y_up      = 4'd7;
    localparam prop_t cam_z_up      = 4'd8;
    localparam prop_t cam_near_clip = 4'd9;
    localparam prop_t cam_far_clip  = 4'd10;
    localparam prop_t cam_h_fov     = 4'd11;
    localparam prop_t cam_v_fov     = 4'd12;

    localparam prop_t lt_type       = 4'd0;  // Low 2 data bits
    localparam prop_t lt_x_loc      = 4'd1;
    localparam prop_t lt_y_loc      = 4'd2;
    localparam prop_t lt_z_loc      = 4'd3;
    localparam prop_t lt_x_fwd      = 4'd4;
    localparam prop_t lt_y_fwd      = 4'd5;
    localparam prop_t lt_z_fwd      = 4'd6;
    localparam prop_t lt_color      = 4'd7;
    localparam prop_t lt_intensity  = 4'd8;

    localparam prop_t sh_x_loc      = 4'd0;
    localparam prop_t sh_y_loc      = 4'd1;
    localparam prop_t sh_z_loc      = 4'd2;
    localparam prop_t sh_r_rot      = 4'd3;  // Rotation quaternion r/i/j/k
    localparam prop_t sh_i_rot      = 4'd4;
    localparam prop_t sh_j_rot      = 4'd5;
    localparam prop_t sh_k_rot      = 4'd6;
    localparam prop_t sh_x_scale    = 4'd7;
    localparam prop_t sh_y_scale    = 4'd8;
    localparam prop_t sh_z_scale    = 4'd9;
    localparam prop_t sh_color      = 4'd10;
    localparam prop_t sh_material   = 4'd11; // Low 2 data bits
    localparam prop_t sh_type       = 4'd12; // Low 4 data bits

endpackage
